// ==== Makefile ====
# Verilator build and run of the SIMT front end testbench

TOP := simt_frontend_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/fetch_if.sv ====
/*
 * Fetcher to instruction cache link
 * Valid/ready handshake carrying the warp's PC and active mask
 */

`timescale 1ns/1ps
`default_nettype none

interface fetch_if import simt_arch_pkg::*; ();

    logic      valid;
    logic      ready;
    pc_t       pc;
    act_mask_t act_mask;
    wid_t      warp_id;

    // Fetcher side, request source
    modport fetcher (
        output valid, pc, act_mask, warp_id,
        input  ready
    );

    // Cache side, request sink
    modport cache (
        input  valid, pc, act_mask, warp_id,
        output ready
    );

endinterface : fetch_if

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
/*
 * Instruction decoder
 * Splits the word into fields, computes the next PC, redirects the fetcher
 * in the accept cycle and registers the decoded instruction
 */

`timescale 1ns/1ps
`default_nettype none

module inst_decoder import simt_arch_pkg::*, simt_isa_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    // From cache
    inst_if.decoder        ic,
    // Redirect to fetcher
    output logic           redir_valid_o,
    output wid_t           redir_warp_id_o,
    output pc_t            redir_pc_o,
    output logic           redir_done_o,
    // Decoded stream
    output logic           dec_valid_o,
    input  wire logic      dec_ready_i,
    output wid_t           dec_warp_id_o,
    output pc_t            dec_pc_o,
    output act_mask_t      dec_act_mask_o,
    output opcode_e        dec_opcode_o,
    output reg_idx_t       dec_rd_o,
    output reg_idx_t       dec_rs_o,
    output imm_t           dec_imm_o,
    output logic           dec_illegal_o
);

    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    imm_t     imm;
    logic     illegal;
    pc_t      next_pc;
    logic     accept;

    // ######################################
    // Field decode
    // ######################################

    assign opcode = opcode_e'(ic.inst[OPC_LSB +: $bits(opcode_e)]);
    assign rd     = ic.inst[RD_LSB +: $bits(reg_idx_t)];
    assign rs     = ic.inst[RS_LSB +: $bits(reg_idx_t)];
    assign imm    = ic.inst[IMM_LSB +: $bits(imm_t)];

    always_comb begin
        case (opcode)
            EXIT, NOP, ADD, SUB, MUL, JMP: illegal = 1'b0;
            default:                       illegal = 1'b1;
        endcase
    end

    // JMP is absolute, everything else falls through
    assign next_pc = (opcode == JMP) ? pc_t'(imm) : ic.pc + pc_t'(1);

    // ######################################
    // Handshake and redirect
    // ######################################

    assign ic.ready = ~dec_valid_o | dec_ready_i;
    assign accept   = ic.valid & ic.ready;

    // One pulse per accepted instruction
    assign redir_valid_o   = accept;
    assign redir_warp_id_o = ic.warp_id;
    assign redir_pc_o      = next_pc;
    assign redir_done_o    = (opcode == EXIT) | illegal;

    // ######################################
    // Output register
    // ######################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (accept) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_warp_id_o  <= ic.warp_id;
            dec_pc_o       <= ic.pc;
            dec_act_mask_o <= ic.act_mask;
            dec_opcode_o   <= opcode;
            dec_rd_o       <= rd;
            dec_rs_o       <= rs;
            dec_imm_o      <= imm;
            dec_illegal_o  <= illegal;
        end
    end

    // Stalled output keeps valid and its payload
    a_dec_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_pc_o)
            && $stable(dec_warp_id_o) && $stable(dec_opcode_o))
        else $error("decoded output changed under back-pressure");

endmodule : inst_decoder

`default_nettype wire

// ==== hdl/inst_if.sv ====
/*
 * Instruction cache to decoder link
 * Looked-up word plus warp id, PC and active mask
 */

`timescale 1ns/1ps
`default_nettype none

interface inst_if import simt_arch_pkg::*, simt_isa_pkg::*; ();

    logic      valid;
    logic      ready;
    pc_t       pc;
    act_mask_t act_mask;
    wid_t      warp_id;
    enc_inst_t inst;

    // Cache side, drives the registered lookup
    modport cache (
        output valid, pc, act_mask, warp_id, inst,
        input  ready
    );

    // Decoder side
    modport decoder (
        input  valid, pc, act_mask, warp_id, inst,
        output ready
    );

endinterface : inst_if

`default_nettype wire

// ==== hdl/instruction_cache.sv ====
/*
 * Instruction cache stage
 * Plain program memory with a write port and one registered lookup stage,
 * addresses past the memory read as the zero word
 */

`timescale 1ns/1ps
`default_nettype none

`include "simt_defines.svh"

module instruction_cache import simt_arch_pkg::*, simt_isa_pkg::*; #(
    parameter int unsigned MemDepth = `SIMT_MEM_DEPTH
) (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    // Program load
    input  wire logic      prog_write_i,
    input  wire pc_t       prog_addr_i,
    input  wire enc_inst_t prog_data_i,
    // From fetcher
    fetch_if.cache         fe,
    // To decoder
    inst_if.cache          ic
);

    localparam int unsigned AddrWidth = $clog2(MemDepth);

    enc_inst_t mem_q [MemDepth];

    logic      valid_q;
    enc_inst_t lookup;
    logic      accept;

    // ######################################
    // Program memory
    // ######################################

    always_ff @(posedge clk_i) begin
        if (prog_write_i && prog_addr_i < pc_t'(MemDepth)) begin
            mem_q[prog_addr_i[AddrWidth-1:0]] <= prog_data_i;
        end
    end

    // Out of range reads give EXIT
    assign lookup = (fe.pc < pc_t'(MemDepth)) ? mem_q[fe.pc[AddrWidth-1:0]] : '0;

    // ######################################
    // Lookup stage
    // ######################################

    // Free slot, or decoder drains it this cycle
    assign fe.ready = ~valid_q | ic.ready;
    assign accept   = fe.valid & fe.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (ic.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Write in the same cycle returns the old word
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ic.inst     <= lookup;
            ic.pc       <= fe.pc;
            ic.act_mask <= fe.act_mask;
            ic.warp_id  <= fe.warp_id;
        end
    end

    assign ic.valid = valid_q;

    a_prog_in_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prog_write_i |-> prog_addr_i < pc_t'(MemDepth))
        else $error("program write to 0x%0h beyond memory", prog_addr_i);

endmodule : instruction_cache

`default_nettype wire

// ==== hdl/simt_arch_pkg.sv ====
/*
 * SIMT architecture types
 * Warp id, program counter, active-thread mask and warp state
 */

`default_nettype none

`include "simt_defines.svh"

package simt_arch_pkg;

    // Warp index into the fetcher tables
    typedef logic [$clog2(`SIMT_NUM_WARPS)-1:0] wid_t;

    // Instruction-word address, not byte address
    typedef logic [`SIMT_PC_WIDTH-1:0] pc_t;

    // One bit per thread in the warp
    typedef logic [`SIMT_WARP_WIDTH-1:0] act_mask_t;

    // Per-warp scheduling state
    typedef enum logic [1:0] {
        IDLE    = 2'd0,  // Not launched or retired
        READY   = 2'd1,  // Eligible for fetch
        WAITING = 2'd2   // One instruction in flight
    } warp_state_e;

endpackage : simt_arch_pkg

`default_nettype wire

// ==== hdl/simt_defines.svh ====
/*
 * SIMT front end sizing
 * Warp count, warp width, PC and instruction widths, program memory depth
 */

`ifndef SIMT_DEFINES_SVH
`define SIMT_DEFINES_SVH

// ######################################
// Warp organisation
// ######################################

// Warps per compute unit
`define SIMT_NUM_WARPS 4
// Threads per warp, one mask bit each
`define SIMT_WARP_WIDTH 8

// ######################################
// Instruction side
// ######################################

// Instruction-word address width
`define SIMT_PC_WIDTH 16
// Program memory words
`define SIMT_MEM_DEPTH 64
`define SIMT_INST_WIDTH 32

`endif

// ==== hdl/simt_frontend.sv ====
/*
 * SIMT instruction front end
 * Fetcher, instruction cache stage and decoder joined by handshake links
 */

`timescale 1ns/1ps
`default_nettype none

module simt_frontend import simt_arch_pkg::*, simt_isa_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    // Program load
    input  wire logic      prog_write_i,
    input  wire pc_t       prog_addr_i,
    input  wire enc_inst_t prog_data_i,
    // Warp launch
    input  wire logic      launch_i,
    input  wire wid_t      launch_warp_i,
    input  wire pc_t       launch_pc_i,
    input  wire act_mask_t launch_mask_i,
    // Decoded stream
    output logic           dec_valid_o,
    input  wire logic      dec_ready_i,
    output wid_t           dec_warp_id_o,
    output pc_t            dec_pc_o,
    output act_mask_t      dec_act_mask_o,
    output opcode_e        dec_opcode_o,
    output reg_idx_t       dec_rd_o,
    output reg_idx_t       dec_rs_o,
    output imm_t           dec_imm_o,
    output logic           dec_illegal_o,
    output logic           busy_o
);

    // Stage links
    fetch_if fe_bus ();
    inst_if  ic_bus ();

    // Decoder back to fetcher
    logic redir_valid;
    wid_t redir_warp_id;
    pc_t  redir_pc;
    logic redir_done;

    warp_fetcher fetch0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .launch_i        (launch_i),
        .launch_warp_i   (launch_warp_i),
        .launch_pc_i     (launch_pc_i),
        .launch_mask_i   (launch_mask_i),
        .redir_valid_i   (redir_valid),
        .redir_warp_id_i (redir_warp_id),
        .redir_pc_i      (redir_pc),
        .redir_done_i    (redir_done),
        .fe              (fe_bus.fetcher),
        .busy_o          (busy_o)
    );

    instruction_cache icache0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .prog_write_i (prog_write_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .fe           (fe_bus.cache),
        .ic           (ic_bus.cache)
    );

    inst_decoder dec0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ic              (ic_bus.decoder),
        .redir_valid_o   (redir_valid),
        .redir_warp_id_o (redir_warp_id),
        .redir_pc_o      (redir_pc),
        .redir_done_o    (redir_done),
        .dec_valid_o     (dec_valid_o),
        .dec_ready_i     (dec_ready_i),
        .dec_warp_id_o   (dec_warp_id_o),
        .dec_pc_o        (dec_pc_o),
        .dec_act_mask_o  (dec_act_mask_o),
        .dec_opcode_o    (dec_opcode_o),
        .dec_rd_o        (dec_rd_o),
        .dec_rs_o        (dec_rs_o),
        .dec_imm_o       (dec_imm_o),
        .dec_illegal_o   (dec_illegal_o)
    );

endmodule : simt_frontend

`default_nettype wire

// ==== hdl/simt_isa_pkg.sv ====
/*
 * SIMT instruction encoding
 * Word type, opcodes and field types with their bit positions
 */

`default_nettype none

`include "simt_defines.svh"

package simt_isa_pkg;

    // Raw instruction word from program memory
    typedef logic [`SIMT_INST_WIDTH-1:0] enc_inst_t;

    // Opcode in bits 31..28, anything above JMP is illegal
    typedef enum logic [3:0] {
        EXIT = 4'd0,  // Zero word retires the warp
        NOP  = 4'd1,
        ADD  = 4'd2,
        SUB  = 4'd3,
        MUL  = 4'd4,
        JMP  = 4'd5   // Absolute jump to imm
    } opcode_e;

    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    // Field positions inside the word
    localparam int unsigned OPC_LSB = 28;
    localparam int unsigned RD_LSB  = 24;
    localparam int unsigned RS_LSB  = 20;
    localparam int unsigned IMM_LSB = 0;

endpackage : simt_isa_pkg

`default_nettype wire

// ==== hdl/warp_fetcher.sv ====
/*
 * Warp fetcher
 * Per-warp PC, mask and state table, round-robin pick of a READY warp,
 * redirect from the decoder returns the warp to READY or IDLE
 */

`timescale 1ns/1ps
`default_nettype none

`include "simt_defines.svh"

module warp_fetcher import simt_arch_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    // Warp launch
    input  wire logic      launch_i,
    input  wire wid_t      launch_warp_i,
    input  wire pc_t       launch_pc_i,
    input  wire act_mask_t launch_mask_i,
    // Redirect from decode
    input  wire logic      redir_valid_i,
    input  wire wid_t      redir_warp_id_i,
    input  wire pc_t       redir_pc_i,
    input  wire logic      redir_done_i,
    // Fetch request
    fetch_if.fetcher       fe,
    output logic           busy_o
);

    // ######################################
    // Warp table
    // ######################################

    warp_state_e state_q [`SIMT_NUM_WARPS];
    pc_t         pc_q    [`SIMT_NUM_WARPS];
    act_mask_t   mask_q  [`SIMT_NUM_WARPS];

    // Last issued warp, search starts one past it
    wid_t rr_q;
    // Request stalled last cycle, keep the same warp
    logic hold_q;
    wid_t hold_wid_q;

    logic pick_found;
    wid_t pick_wid;
    wid_t sel_wid;
    logic issue;

    // ######################################
    // Round-robin pick
    // ######################################

    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_wid   = rr_q;
        for (int i = 1; i <= `SIMT_NUM_WARPS; i++) begin
            idx = (int'(rr_q) + i) % `SIMT_NUM_WARPS;
            // First READY warp after the pointer wins
            if (!pick_found && state_q[idx] == READY) begin
                pick_found = 1'b1;
                pick_wid   = wid_t'(idx);
            end
        end
    end

    // Stalled request keeps its warp so data stays stable
    assign sel_wid     = hold_q ? hold_wid_q : pick_wid;
    assign fe.valid    = hold_q | pick_found;
    assign fe.warp_id  = sel_wid;
    assign fe.pc       = pc_q[sel_wid];
    assign fe.act_mask = mask_q[sel_wid];

    assign issue = fe.valid & fe.ready;

    // ######################################
    // State update
    // ######################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
                state_q[w] <= IDLE;
            end
            rr_q       <= wid_t'(`SIMT_NUM_WARPS - 1);
            hold_q     <= 1'b0;
            hold_wid_q <= '0;
        end else begin
            hold_q     <= fe.valid & ~fe.ready;
            hold_wid_q <= sel_wid;
            if (issue) begin
                rr_q <= sel_wid;
            end
            for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
                // Issue, redirect and launch never hit the same warp
                if (issue && sel_wid == wid_t'(w)) begin
                    state_q[w] <= WAITING;
                end
                if (redir_valid_i && redir_warp_id_i == wid_t'(w)) begin
                    state_q[w] <= redir_done_i ? IDLE : READY;
                end
                // Launch only takes an IDLE warp
                if (launch_i && launch_warp_i == wid_t'(w) && state_q[w] == IDLE) begin
                    state_q[w] <= READY;
                end
            end
        end
    end

    // PC and mask payload
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            if (redir_valid_i && redir_warp_id_i == wid_t'(w)) begin
                pc_q[w] <= redir_pc_i;
            end
            if (launch_i && launch_warp_i == wid_t'(w) && state_q[w] == IDLE) begin
                pc_q[w]   <= launch_pc_i;
                mask_q[w] <= launch_mask_i;
            end
        end
    end

    always_comb begin
        busy_o = 1'b0;
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            if (state_q[w] != IDLE) begin
                busy_o = 1'b1;
            end
        end
    end

    // Decoder only answers for a warp with an instruction in flight
    a_redir_waiting : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redir_valid_i |-> state_q[redir_warp_id_i] == WAITING)
        else $error("redirect for warp %0d which is not WAITING", redir_warp_id_i);

endmodule : warp_fetcher

`default_nettype wire

// ==== testbench/simt_frontend_tb.sv ====
/*
 * SIMT front end testbench
 * Loads a program, launches warps from a table and matches every decoded
 * output against a per-warp expected trace, with random output stalls
 */

`timescale 1ns/1ps
`default_nettype none

`include "simt_defines.svh"

module simt_frontend_tb import simt_arch_pkg::*, simt_isa_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_PROG   = 13;
    localparam int NUM_LAUNCH = 6;
    localparam int NUM_TRACE  = 14;

    typedef struct packed {
        pc_t       addr;
        enc_inst_t word;
    } prog_t;

    typedef struct packed {
        logic      phase;
        wid_t      warp;
        pc_t       pc;
        act_mask_t mask;
        logic      takes;  // 0 when the warp is still running
    } launch_t;

    typedef struct packed {
        wid_t     warp;
        pc_t      pc;
        opcode_e  opc;
        reg_idx_t rd;
        reg_idx_t rs;
        imm_t     imm;
        logic     ill;
    } trace_t;

    // ######################################
    // Stimulus and expected tables
    // ######################################

    // Straight line at 0, jump at 8, memory end at 62, illegal at 31
    localparam prog_t PROG [NUM_PROG] = '{
        '{16'd0,  32'h2120_0011}, '{16'd1,  32'h3340_0022}, '{16'd2,  32'h4560_0033},
        '{16'd3,  32'h1000_0000}, '{16'd4,  32'h0000_0000},
        '{16'd8,  32'h2780_0100}, '{16'd9,  32'h5000_0014},
        '{16'd20, 32'h39a0_0abc}, '{16'd21, 32'h0000_0000},
        '{16'd62, 32'h1ab0_1234}, '{16'd63, 32'h4cd0_ffff},
        '{16'd30, 32'h2f00_0007}, '{16'd31, 32'h9123_4567}
    };

    // Phase 0 runs warp 0 alone, phase 1 runs all four
    localparam launch_t LAUNCH [NUM_LAUNCH] = '{
        '{1'b0, 2'd0, 16'd0,  8'hff, 1'b1},
        '{1'b1, 2'd0, 16'd0,  8'h0f, 1'b1},
        '{1'b1, 2'd1, 16'd8,  8'ha5, 1'b1},
        '{1'b1, 2'd2, 16'd62, 8'h3c, 1'b1},
        '{1'b1, 2'd3, 16'd30, 8'h81, 1'b1},
        '{1'b1, 2'd1, 16'd0,  8'h11, 1'b0}
    };

    localparam trace_t TRACE [NUM_TRACE] = '{
        '{2'd0, 16'd0,  ADD,  4'h1, 4'h2, 16'h0011, 1'b0},
        '{2'd0, 16'd1,  SUB,  4'h3, 4'h4, 16'h0022, 1'b0},
        '{2'd0, 16'd2,  MUL,  4'h5, 4'h6, 16'h0033, 1'b0},
        '{2'd0, 16'd3,  NOP,  4'h0, 4'h0, 16'h0000, 1'b0},
        '{2'd0, 16'd4,  EXIT, 4'h0, 4'h0, 16'h0000, 1'b0},
        '{2'd1, 16'd8,  ADD,  4'h7, 4'h8, 16'h0100, 1'b0},
        '{2'd1, 16'd9,  JMP,  4'h0, 4'h0, 16'h0014, 1'b0},
        '{2'd1, 16'd20, SUB,  4'h9, 4'ha, 16'h0abc, 1'b0},
        '{2'd1, 16'd21, EXIT, 4'h0, 4'h0, 16'h0000, 1'b0},
        '{2'd2, 16'd62, NOP,  4'ha, 4'hb, 16'h1234, 1'b0},
        '{2'd2, 16'd63, MUL,  4'hc, 4'hd, 16'hffff, 1'b0},
        '{2'd2, 16'd64, EXIT, 4'h0, 4'h0, 16'h0000, 1'b0},  // past the memory end
        '{2'd3, 16'd30, ADD,  4'hf, 4'h0, 16'h0007, 1'b0},
        '{2'd3, 16'd31, opcode_e'(4'h9), 4'h1, 4'h2, 16'h4567, 1'b1}
    };

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      prog_write_i;
    pc_t       prog_addr_i;
    enc_inst_t prog_data_i;
    logic      launch_i;
    wid_t      launch_warp_i;
    pc_t       launch_pc_i;
    act_mask_t launch_mask_i;
    logic      dec_valid_o;
    logic      dec_ready_i;
    wid_t      dec_warp_id_o;
    pc_t       dec_pc_o;
    act_mask_t dec_act_mask_o;
    opcode_e   dec_opcode_o;
    reg_idx_t  dec_rd_o;
    reg_idx_t  dec_rs_o;
    imm_t      dec_imm_o;
    logic      dec_illegal_o;
    logic      busy_o;

    int        seed;
    int        errors;
    int        outputs;
    int        seen [`SIMT_NUM_WARPS];
    act_mask_t exp_mask [`SIMT_NUM_WARPS];

    simt_frontend dut0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .prog_write_i   (prog_write_i),
        .prog_addr_i    (prog_addr_i),
        .prog_data_i    (prog_data_i),
        .launch_i       (launch_i),
        .launch_warp_i  (launch_warp_i),
        .launch_pc_i    (launch_pc_i),
        .launch_mask_i  (launch_mask_i),
        .dec_valid_o    (dec_valid_o),
        .dec_ready_i    (dec_ready_i),
        .dec_warp_id_o  (dec_warp_id_o),
        .dec_pc_o       (dec_pc_o),
        .dec_act_mask_o (dec_act_mask_o),
        .dec_opcode_o   (dec_opcode_o),
        .dec_rd_o       (dec_rd_o),
        .dec_rs_o       (dec_rs_o),
        .dec_imm_o      (dec_imm_o),
        .dec_illegal_o  (dec_illegal_o),
        .busy_o         (busy_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ######################################
    // Compare tasks
    // ######################################

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_opcode(input string name, input opcode_e got, input opcode_e exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input act_mask_t got, input act_mask_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_imm(input string name, input imm_t got, input imm_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // n-th trace row of warp w, -1 past its end
    function automatic int find_entry(input int w, input int n);
        int k;
        find_entry = -1;
        k = 0;
        for (int i = 0; i < NUM_TRACE; i++) begin
            if (int'(TRACE[i].warp) == w) begin
                if (k == n) find_entry = i;
                k++;
            end
        end
    endfunction

    function automatic int trace_len(input int w);
        trace_len = 0;
        for (int i = 0; i < NUM_TRACE; i++) begin
            if (int'(TRACE[i].warp) == w) trace_len++;
        end
    endfunction

    function automatic int phase_outputs(input int phase);
        phase_outputs = 0;
        for (int i = 0; i < NUM_LAUNCH; i++) begin
            if (int'(LAUNCH[i].phase) == phase && LAUNCH[i].takes) begin
                phase_outputs += trace_len(int'(LAUNCH[i].warp));
            end
        end
    endfunction

    task automatic check_output();
        int w;
        int idx;
        w = int'(dec_warp_id_o);
        idx = find_entry(w, seen[w]);
        if (idx < 0) begin
            $display("unexpected extra output from warp %0d at pc 0x%h", w, dec_pc_o);
            errors++;
        end else begin
            check_pc("dec_pc_o", dec_pc_o, TRACE[idx].pc);
            check_opcode("dec_opcode_o", dec_opcode_o, TRACE[idx].opc);
            check_reg("dec_rd_o", dec_rd_o, TRACE[idx].rd);
            check_reg("dec_rs_o", dec_rs_o, TRACE[idx].rs);
            check_imm("dec_imm_o", dec_imm_o, TRACE[idx].imm);
            check_bit("dec_illegal_o", dec_illegal_o, TRACE[idx].ill);
            check_mask("dec_act_mask_o", dec_act_mask_o, exp_mask[w]);
        end
        seen[w]++;
        outputs++;
    endtask

    // ######################################
    // Phase runner
    // ######################################

    // Launches and output collection share one falling-edge loop
    task automatic run_phase(input int phase);
        int li;
        int remaining;
        int cycle;
        li = 0;
        cycle = 0;
        remaining = phase_outputs(phase);
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) seen[w] = 0;
        while (remaining > 0 || li < NUM_LAUNCH) begin
            @(negedge clk_i);
            cycle++;
            launch_i = 1'b0;
            while (li < NUM_LAUNCH && int'(LAUNCH[li].phase) != phase) li++;
            if (li < NUM_LAUNCH) begin
                launch_i      = 1'b1;
                launch_warp_i = LAUNCH[li].warp;
                launch_pc_i   = LAUNCH[li].pc;
                launch_mask_i = LAUNCH[li].mask;
                if (LAUNCH[li].takes) exp_mask[LAUNCH[li].warp] = LAUNCH[li].mask;
                li++;
            end
            // First launch has landed by the second cycle
            if (cycle == 2) check_bit("busy_o", busy_o, 1'b1);
            // Phase 0 never stalls the output
            dec_ready_i = (phase == 0) ? 1'b1 : (($random(seed) & 32'h3) != 0);
            if (dec_valid_o && dec_ready_i) begin
                check_output();
                remaining--;
            end
        end
        // Nothing more may come out once every warp has retired
        repeat (8) begin
            @(negedge clk_i);
            launch_i = 1'b0;
            dec_ready_i = 1'b1;
            if (dec_valid_o) begin
                $display("output from warp %0d after the phase finished", dec_warp_id_o);
                errors++;
            end
        end
        check_bit("busy_o", busy_o, 1'b0);
    endtask

    // ######################################
    // Main sequence and watchdog
    // ######################################

    initial begin
        seed          = 32'hf273;
        errors        = 0;
        outputs       = 0;
        rst_n_i       = 1'b0;
        prog_write_i  = 1'b0;
        prog_addr_i   = '0;
        prog_data_i   = '0;
        launch_i      = 1'b0;
        launch_warp_i = '0;
        launch_pc_i   = '0;
        launch_mask_i = '0;
        dec_ready_i   = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        for (int i = 0; i < NUM_PROG; i++) begin
            @(negedge clk_i);
            prog_write_i = 1'b1;
            prog_addr_i  = PROG[i].addr;
            prog_data_i  = PROG[i].word;
        end
        @(negedge clk_i);
        prog_write_i = 1'b0;
        run_phase(0);
        run_phase(1);
        $display("checks done: %0d errors over %0d outputs", errors, outputs);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        // Generous budget per expected output under random stalls
        limit = NUM_PROG + 20 * (phase_outputs(0) + phase_outputs(1)) + 100;
        #(limit * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", limit);
        $display("checks done: %0d errors over %0d outputs", errors, outputs);
        $display("sim failed");
        $finish;
    end

endmodule : simt_frontend_tb

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/simt_arch_pkg.sv
hdl/simt_isa_pkg.sv
hdl/fetch_if.sv
hdl/inst_if.sv
hdl/warp_fetcher.sv
hdl/instruction_cache.sv
hdl/inst_decoder.sv
hdl/simt_frontend.sv
testbench/simt_frontend_tb.sv
